//--- tb.f
+incdir+hdl
hdl/slink_pkg.sv
hdl/source_ram.sv
hdl/frame_copy.sv
hdl/tx_buffer.sv
hdl/slink_tx.sv
hdl/slink_top.sv
sim/tb_slink_top.sv

//--- Bender.yml
package:
  name: slink_frame_mover

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/slink_pkg.sv
      - hdl/source_ram.sv
      - hdl/frame_copy.sv
      - hdl/tx_buffer.sv
      - hdl/slink_tx.sv
      - hdl/slink_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/tb_slink_top.sv

//--- sim/tb_slink_top.sv
// --------------------------------------------------
// Testbench for the frame mover top level
// Partner model returns one credit per beat after a table delay
// Assumes the default frame length and credit count of the settings header
// --------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slink_settings.svh"

module tb_slink_top;

    localparam int num_tests = 6;
    localparam int max_delay = 3;
    localparam int idle_wait = 60;
    // Watchdog limit in cycles
    localparam int timeout_cycles =
        4 * num_tests * (`SLINK_FRAME_LEN + 20) * (max_delay + 1);

    // Delay 4 means random 0 to 3 and abort 0 means no abort
    typedef struct packed {
        logic       random_fill;
        logic [7:0] abort_cyc;
        logic [2:0] delay;
        logic       retrig;
        logic [1:0] exp_frames;
    } test_row_t;

    logic                  clk;
    logic                  reset;
    slink_pkg::host_wr_t   host_wr;
    logic                  copy_en;
    slink_pkg::link_beat_t link_out;
    logic                  credit_return;
    logic                  tx_busy;

    test_row_t   tests [num_tests];
    logic [7:0]  model_mem [`SLINK_FRAME_LEN];
    logic [31:0] lfsr;
    int          cycle_count;
    int          due_q [$];
    int          cur_delay;
    int          beats_sent;
    int          credits_back;
    int          frames_seen;
    int          data_idx;
    logic        in_frame;
    logic [4:0]  exp_seq;
    int          data_errs;
    int          hdr_errs;
    int          credit_errs;
    int          frame_errs;

    slink_top slink_top_inst (
        .clk           (clk),
        .reset         (reset),
        .host_wr       (host_wr),
        .copy_en       (copy_en),
        .link_out      (link_out),
        .credit_return (credit_return),
        .tx_busy       (tx_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            v    = {v[6:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic test_row_t make_row(input logic random_fill, input int abort_cyc,
                                           input int delay, input logic retrig,
                                           input int exp_frames);
        test_row_t r;
        r.random_fill = random_fill;
        r.abort_cyc   = 8'(abort_cyc);
        r.delay       = 3'(delay);
        r.retrig      = retrig;
        r.exp_frames  = 2'(exp_frames);
        return r;
    endfunction

    task automatic load_table();
        // Row 0 checks the first edge after reset
        tests[0] = make_row(1'b1, 0, 0, 1'b0, 1);
        tests[1] = make_row(1'b0, 0, 3, 1'b0, 1);
        // Early abort a few cycles into the read
        tests[2] = make_row(1'b1, 3, 0, 1'b0, 0);
        // Second rise while the frame is on the link
        tests[3] = make_row(1'b1, 0, 4, 1'b1, 1);
        tests[4] = make_row(1'b0, 20, 1, 1'b0, 0);
        tests[5] = make_row(1'b1, 0, 2, 1'b0, 1);
    endtask

    // Window fill through the host port with a model copy
    task automatic fill_window(input logic random_fill, input int t);
        int                  i;
        logic [7:0]          b;
        slink_pkg::host_wr_t w;
        w.valid = 1'b1;
        for (i = 0; i < `SLINK_FRAME_LEN; i++)
        begin
            w.addr = `SLINK_WIN_BASE + 24'(i);
            if (random_fill)
            begin
                take_bits(8, b);
            end
            else
            begin
                b = w.addr[7:0] + 8'(t);
            end
            w.data       = b;
            model_mem[i] = b;
            @(posedge clk);
            host_wr <= w;
        end
        // Same low bits in another region must be ignored
        w.addr = `SLINK_WIN_BASE ^ 24'h100000;
        w.data = ~model_mem[0];
        @(posedge clk);
        host_wr <= w;
        @(posedge clk);
        host_wr <= '0;
    endtask

    task automatic wait_busy(input logic level);
        @(negedge clk);
        while (tx_busy !== level)
        begin
            @(negedge clk);
        end
    endtask

    // --------------------------------------------------
    // Link partner and scoreboard
    // --------------------------------------------------
    task automatic check_header(input slink_pkg::beat_payload_u p);
        logic [`SLINK_BUF_ADDR_W-1:0] exp_len;
        exp_len = `SLINK_BUF_ADDR_W'(`SLINK_FRAME_LEN);
        assert (!in_frame)
        else
        begin
            hdr_errs++;
            $display("Header beat arrived inside a frame after %0d data beats", data_idx);
        end
        assert (p.hdr.len == exp_len)
        else
        begin
            hdr_errs++;
            $display("CHECK FAILED link_out.payload.hdr.len: got 0x%0h expected 0x%0h",
                     p.hdr.len, exp_len);
        end
        assert (p.hdr.seq == exp_seq)
        else
        begin
            hdr_errs++;
            $display("CHECK FAILED link_out.payload.hdr.seq: got 0x%0h expected 0x%0h",
                     p.hdr.seq, exp_seq);
        end
        in_frame = 1'b1;
        data_idx = 0;
    endtask

    task automatic check_data(input slink_pkg::beat_payload_u p);
        assert (in_frame)
        else
        begin
            data_errs++;
            $display("Data beat arrived without a header before it");
        end
        if (in_frame)
        begin
            assert (p.dat.pad == 8'h00)
            else
            begin
                data_errs++;
                $display("CHECK FAILED link_out.payload.dat.pad[%0d]: got 0x%0h expected 0x0",
                         data_idx, p.dat.pad);
            end
            assert (p.dat.data == model_mem[data_idx])
            else
            begin
                data_errs++;
                $display("CHECK FAILED link_out.payload.dat.data[%0d]: got 0x%0h expected 0x%0h",
                         data_idx, p.dat.data, model_mem[data_idx]);
            end
            data_idx++;
            // Frame closes on its last data beat
            if (data_idx == `SLINK_FRAME_LEN)
            begin
                in_frame = 1'b0;
                frames_seen++;
                exp_seq++;
            end
        end
    endtask

    // Beats and returns sampled mid-cycle
    always @(negedge clk)
    begin : partner_rx
        logic [7:0] gap;
        if (!reset && link_out.valid)
        begin
            beats_sent++;
            assert (beats_sent - credits_back <= `SLINK_CREDITS)
            else
            begin
                credit_errs++;
                $display("CHECK FAILED link_out.valid outstanding: got 0x%0h limit 0x%0h",
                         beats_sent - credits_back, `SLINK_CREDITS);
            end
            if (link_out.kind == slink_pkg::beat_hdr)
            begin
                check_header(link_out.payload);
            end
            else
            begin
                check_data(link_out.payload);
            end
            gap = 8'(cur_delay);
            if (cur_delay > max_delay)
            begin
                take_bits(2, gap);
            end
            due_q.push_back(cycle_count + gap + 1);
        end
        // Consumed by the DUT at the next rising edge
        if (credit_return)
        begin
            credits_back++;
        end
    end

    // Credit pulses at most one per cycle and the watchdog
    always @(posedge clk)
    begin : partner_tx
        cycle_count++;
        credit_return <= 1'b0;
        if (due_q.size() > 0 && due_q[0] <= cycle_count)
        begin
            void'(due_q.pop_front());
            credit_return <= 1'b1;
        end
        if (cycle_count >= timeout_cycles)
        begin
            $display("Timeout: run stopped after %0d cycles", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    task automatic run_test(input int t);
        test_row_t row;
        int        frames_before;
        int        beats_before;
        int        beats_after;
        row       = tests[t];
        cur_delay = row.delay;
        fill_window(row.random_fill, t);
        frames_before = frames_seen;
        beats_before  = beats_sent;
        @(posedge clk);
        copy_en <= 1'b1;
        if (row.abort_cyc != 0)
        begin
            repeat (row.abort_cyc) @(posedge clk);
            copy_en <= 1'b0;
            repeat (idle_wait) @(negedge clk);
            assert (beats_sent == beats_before)
            else
            begin
                frame_errs++;
                $display("CHECK FAILED link_out.valid beats after abort: got 0x%0h expected 0x0",
                         beats_sent - beats_before);
            end
        end
        else
        begin
            wait_busy(1'b1);
            if (row.retrig)
            begin
                // Low then high again while the frame is still going out
                @(posedge clk);
                copy_en <= 1'b0;
                repeat (4) @(posedge clk);
                copy_en <= 1'b1;
            end
            wait_busy(1'b0);
            beats_after = beats_sent;
            // No second frame may follow while the enable stays high
            repeat (idle_wait) @(negedge clk);
            assert (beats_sent == beats_after)
            else
            begin
                frame_errs++;
                $display("CHECK FAILED link_out.valid beats after frame: got 0x%0h expected 0x0",
                         beats_sent - beats_after);
            end
        end
        assert (frames_seen - frames_before == row.exp_frames)
        else
        begin
            frame_errs++;
            $display("CHECK FAILED frame count test %0d: got 0x%0h expected 0x%0h",
                     t, frames_seen - frames_before, row.exp_frames);
        end
        @(posedge clk);
        copy_en <= 1'b0;
        repeat (5) @(posedge clk);
    endtask

    initial
    begin
        int t;
        int total;
        reset         = 1'b1;
        host_wr       = '0;
        copy_en       = 1'b0;
        credit_return = 1'b0;
        lfsr          = 32'ha61b_455a;
        in_frame      = 1'b0;
        exp_seq       = '0;
        cur_delay     = 0;
        load_table();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        assert (tx_busy == 1'b0)
        else
        begin
            frame_errs++;
            $display("CHECK FAILED tx_busy after reset: got 0x%0h expected 0x0", tx_busy);
        end

        for (t = 0; t < num_tests; t++)
        begin
            run_test(t);
        end

        // Let every pending credit come back
        while (due_q.size() != 0)
        begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        assert (credits_back == beats_sent)
        else
        begin
            credit_errs++;
            $display("CHECK FAILED credit_return count: got 0x%0h expected 0x%0h",
                     credits_back, beats_sent);
        end
        assert (!in_frame)
        else
        begin
            data_errs++;
            $display("Last frame ended after only %0d data beats", data_idx);
        end

        total = data_errs + hdr_errs + credit_errs + frame_errs;
        $display("Errors: data %0d, header %0d, credit %0d, frame %0d, total %0d",
                 data_errs, hdr_errs, credit_errs, frame_errs, total);
        if (total == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/slink_top.sv
// -----------------------------------------------
// Frame mover top, host fill to link output
// One frame at a time; copy_en edges during tx_busy are lost
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slink_settings.svh"

module slink_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire slink_pkg::host_wr_t host_wr,
    input  wire                     copy_en,
    output slink_pkg::link_beat_t   link_out,
    input  wire                     credit_return,
    output logic                    tx_busy
);

    // Source read path
    logic                         rd_en;
    logic [`SLINK_SRC_ADDR_W-1:0] rd_addr;
    logic [7:0]                   rd_data;

    // Buffer write path
    logic                         buf_wr_en;
    logic [`SLINK_BUF_ADDR_W-1:0] buf_wr_addr;
    logic [7:0]                   buf_wr_data;
    logic                         frame_ready;

    // Buffer read path
    logic [`SLINK_BUF_ADDR_W-1:0] buf_rd_addr;
    logic [7:0]                   buf_rd_data;

    source_ram source_ram_inst (
        .clk     (clk),
        .host_wr (host_wr),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    frame_copy frame_copy_inst (
        .clk         (clk),
        .reset       (reset),
        .copy_en     (copy_en),
        .tx_busy     (tx_busy),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .buf_wr_en   (buf_wr_en),
        .buf_wr_addr (buf_wr_addr),
        .buf_wr_data (buf_wr_data),
        .frame_ready (frame_ready)
    );

    tx_buffer tx_buffer_inst (
        .clk     (clk),
        .wr_en   (buf_wr_en),
        .wr_addr (buf_wr_addr),
        .wr_data (buf_wr_data),
        .rd_addr (buf_rd_addr),
        .rd_data (buf_rd_data)
    );

    slink_tx slink_tx_inst (
        .clk           (clk),
        .reset         (reset),
        .frame_ready   (frame_ready),
        .buf_rd_addr   (buf_rd_addr),
        .buf_rd_data   (buf_rd_data),
        .link_out      (link_out),
        .credit_return (credit_return),
        .tx_busy       (tx_busy)
    );

endmodule

`default_nettype wire

//--- hdl/slink_tx.sv
// -----------------------------------------------
// Sends a frame as one header beat then data beats
// One credit per beat; credit_return pulses add one back
// tx_busy covers the whole frame, buffer must not change then
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slink_settings.svh"

module slink_tx (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          frame_ready,
    output logic [`SLINK_BUF_ADDR_W-1:0] buf_rd_addr,
    input  wire [7:0]                    buf_rd_data,
    output slink_pkg::link_beat_t        link_out,
    input  wire                          credit_return,
    output logic                         tx_busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_hdr,
        st_data
    } state_e;

    localparam int cred_w = $clog2(`SLINK_CREDITS + 1);
    localparam logic [cred_w-1:0] cred_max = cred_w'(`SLINK_CREDITS);
    localparam logic [`SLINK_BUF_ADDR_W-1:0] last_idx =
        `SLINK_BUF_ADDR_W'(`SLINK_FRAME_LEN - 1);

    state_e                       state;
    logic [cred_w-1:0]            credits;
    slink_pkg::seq_t              seq;
    logic [`SLINK_BUF_ADDR_W-1:0] idx;
    logic                         send;

    // A beat goes out whenever there is something to send and a credit
    assign send    = (state != st_idle) && (credits != '0);
    assign tx_busy = (state != st_idle);

    // Prefetch, buf_rd_data always holds byte idx
    assign buf_rd_addr = (send && (state == st_data)) ? idx + 1'b1 : idx;

    // -----------------------------------------------
    // Beat build, payload view chosen by kind
    // -----------------------------------------------
    always_comb
    begin
        link_out       = '0;
        link_out.valid = send;
        if (state == st_hdr)
        begin
            link_out.kind             = slink_pkg::beat_hdr;
            link_out.payload.hdr.len  = `SLINK_BUF_ADDR_W'(`SLINK_FRAME_LEN);
            link_out.payload.hdr.seq  = seq;
        end
        else
        begin
            link_out.kind             = slink_pkg::beat_data;
            link_out.payload.dat.data = buf_rd_data;
        end
    end

    // -----------------------------------------------
    // Credits, sequence and frame FSM
    // -----------------------------------------------
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state   <= st_idle;
            credits <= cred_max;
            seq     <= '0;
            idx     <= '0;
        end
        else
        begin
            // Send and return together cancel out
            case ({send, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01:
                begin
                    // Extra returns clamp at the reset value
                    if (credits != cred_max)
                    begin
                        credits <= credits + 1'b1;
                    end
                end
                default: ;
            endcase

            case (state)
                st_idle:
                begin
                    if (frame_ready)
                    begin
                        state <= st_hdr;
                        idx   <= '0;
                    end
                end

                st_hdr:
                begin
                    if (send)
                    begin
                        state <= st_data;
                    end
                end

                st_data:
                begin
                    if (send)
                    begin
                        if (idx == last_idx)
                        begin
                            state <= st_idle;
                            seq   <= seq + 1'b1;
                        end
                        else
                        begin
                            idx <= idx + 1'b1;
                        end
                    end
                end

                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/tx_buffer.sv
// -----------------------------------------------
// One-frame byte buffer, one write and one read port
// Read data is registered, valid the cycle after rd_addr
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slink_settings.svh"

module tx_buffer (
    input  wire                          clk,
    input  wire                          wr_en,
    input  wire [`SLINK_BUF_ADDR_W-1:0]  wr_addr,
    input  wire [7:0]                    wr_data,
    input  wire [`SLINK_BUF_ADDR_W-1:0]  rd_addr,
    output logic [7:0]                   rd_data
);

    localparam int buf_depth = 2 ** `SLINK_BUF_ADDR_W;

    logic [7:0] mem [buf_depth];

    // Write side, copy engine
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read side, transmitter
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- hdl/frame_copy.sv
// -----------------------------------------------
// Copies one frame from the source window to the tx buffer
// Starts on a synchronized rising edge of copy_en
// Enable low at any point aborts; no frame_ready then
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slink_settings.svh"

module frame_copy (
    input  wire                           clk,
    input  wire                           reset,
    input  wire                           copy_en,
    input  wire                           tx_busy,
    output logic                          rd_en,
    output logic [`SLINK_SRC_ADDR_W-1:0]  rd_addr,
    input  wire [7:0]                     rd_data,
    output logic                          buf_wr_en,
    output logic [`SLINK_BUF_ADDR_W-1:0]  buf_wr_addr,
    output logic [7:0]                    buf_wr_data,
    output logic                          frame_ready
);

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_drain,
        st_done
    } state_e;

    localparam logic [`SLINK_BUF_ADDR_W-1:0] last_idx =
        `SLINK_BUF_ADDR_W'(`SLINK_FRAME_LEN - 1);

    state_e                       state;
    logic [1:0]                   en_sync;
    logic                         en_prev;
    logic                         en_rise;
    logic [`SLINK_BUF_ADDR_W-1:0] issue_cnt;
    logic [`SLINK_BUF_ADDR_W-1:0] wr_idx;
    logic [`SLINK_RD_LAT-1:0]     vld_pipe;
    logic                         data_vld;

    // -----------------------------------------------
    // Enable synchronizer and edge detect
    // -----------------------------------------------
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            en_sync <= 2'b00;
            en_prev <= 1'b0;
        end
        else
        begin
            en_sync <= {en_sync[0], copy_en};
            en_prev <= en_sync[1];
        end
    end

    // Rise seen once the second flop has gone high
    assign en_rise = en_sync[1] & ~en_prev;

    // Tag for read data arriving this cycle
    assign data_vld = vld_pipe[`SLINK_RD_LAT-1];

    // Buffer writes straight from the read data stage
    assign buf_wr_en   = data_vld;
    assign buf_wr_addr = wr_idx;
    assign buf_wr_data = rd_data;

    // -----------------------------------------------
    // Copy FSM
    // -----------------------------------------------
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= st_idle;
            rd_en       <= 1'b0;
            rd_addr     <= '0;
            issue_cnt   <= '0;
            wr_idx      <= '0;
            vld_pipe    <= '0;
            frame_ready <= 1'b0;
        end
        else
        begin
            frame_ready <= 1'b0;
            // One tag per issued read, several in flight
            vld_pipe <= {vld_pipe[`SLINK_RD_LAT-2:0], rd_en};
            // Write address moves only on real data
            if (data_vld)
            begin
                wr_idx <= wr_idx + 1'b1;
            end

            case (state)
                st_idle:
                begin
                    // Buffer busy, start request dropped
                    if (en_rise && !tx_busy)
                    begin
                        state     <= st_read;
                        rd_en     <= 1'b1;
                        rd_addr   <= `SLINK_WIN_BASE;
                        issue_cnt <= '0;
                        wr_idx    <= '0;
                    end
                end

                st_read:
                begin
                    if (!en_sync[1])
                    begin
                        // Abort, in-flight reads discarded
                        state    <= st_idle;
                        rd_en    <= 1'b0;
                        vld_pipe <= '0;
                    end
                    else if (issue_cnt == last_idx)
                    begin
                        rd_en <= 1'b0;
                        state <= st_drain;
                    end
                    else
                    begin
                        rd_addr   <= rd_addr + 1'b1;
                        issue_cnt <= issue_cnt + 1'b1;
                    end
                end

                st_drain:
                begin
                    if (!en_sync[1])
                    begin
                        state    <= st_idle;
                        vld_pipe <= '0;
                    end
                    else if (data_vld && (wr_idx == last_idx))
                    begin
                        // Last byte written this cycle
                        state       <= st_done;
                        frame_ready <= 1'b1;
                    end
                end

                st_done:
                begin
                    state <= st_idle;
                end

                default:
                begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/source_ram.sv
// -----------------------------------------------
// Source memory for the frame window region only
// Writes and reads outside the region are dropped / return 0
// Read data appears exactly two cycles after rd_en
// -----------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "slink_settings.svh"

module source_ram (
    input  wire                           clk,
    input  wire slink_pkg::host_wr_t      host_wr,
    input  wire                           rd_en,
    input  wire [`SLINK_SRC_ADDR_W-1:0]   rd_addr,
    output logic [7:0]                    rd_data
);

    localparam int ram_depth = 2 ** `SLINK_RAM_ADDR_W;
    localparam logic [`SLINK_SRC_ADDR_W-1:0] win_base = `SLINK_WIN_BASE;

    logic [7:0]                   mem [ram_depth];
    logic                         wr_hit;
    logic                         rd_hit;
    logic                         rd_hit_q;
    logic [`SLINK_RAM_ADDR_W-1:0] rd_addr_q;

    // Region decode on the upper address bits
    assign wr_hit = host_wr.valid &&
        (host_wr.addr[`SLINK_SRC_ADDR_W-1:`SLINK_RAM_ADDR_W] ==
         win_base[`SLINK_SRC_ADDR_W-1:`SLINK_RAM_ADDR_W]);
    assign rd_hit =
        (rd_addr[`SLINK_SRC_ADDR_W-1:`SLINK_RAM_ADDR_W] ==
         win_base[`SLINK_SRC_ADDR_W-1:`SLINK_RAM_ADDR_W]);

    // -----------------------------------------------
    // Host write port
    // -----------------------------------------------
    always_ff @(posedge clk)
    begin
        if (wr_hit)
        begin
            mem[host_wr.addr[`SLINK_RAM_ADDR_W-1:0]] <= host_wr.data;
        end
    end

    // -----------------------------------------------
    // Read port, address stage then data stage
    // -----------------------------------------------
    always_ff @(posedge clk)
    begin
        // Stage 1 holds the last accepted address
        if (rd_en)
        begin
            rd_addr_q <= rd_addr[`SLINK_RAM_ADDR_W-1:0];
            rd_hit_q  <= rd_hit;
        end
        // Stage 2, miss reads back as zero
        rd_data <= rd_hit_q ? mem[rd_addr_q] : 8'h00;
    end

endmodule

`default_nettype wire

//--- hdl/slink_pkg.sv
// -----------------------------------------------
// Shared types for the serial link frame mover
// Beat payload is 16 bits, decoded by kind
// -----------------------------------------------
`default_nettype none

`include "slink_settings.svh"

package slink_pkg;

    // Host write into the source window
    typedef struct packed {
        logic                         valid;
        logic [`SLINK_SRC_ADDR_W-1:0] addr;
        logic [7:0]                   data;
    } host_wr_t;

    // Beat type on the link
    typedef enum logic {
        beat_hdr  = 1'b0,
        beat_data = 1'b1
    } beat_kind_e;

    // Frame sequence number, wraps at 32
    typedef logic [4:0] seq_t;

    // Header view of a payload
    typedef struct packed {
        logic [`SLINK_BUF_ADDR_W-1:0] len;
        seq_t                         seq;
    } hdr_fields_t;

    // Data view, byte in the low half
    typedef struct packed {
        logic [7:0] pad;
        logic [7:0] data;
    } data_fields_t;

    // Same 16 bits, two decodings
    typedef union packed {
        hdr_fields_t  hdr;
        data_fields_t dat;
    } beat_payload_u;

    // One link beat
    typedef struct packed {
        logic          valid;
        beat_kind_e    kind;
        beat_payload_u payload;
    } link_beat_t;

endpackage

`default_nettype wire

//--- hdl/slink_settings.svh
// -----------------------------------------------
// Build-time settings for the serial link frame mover
// Frame length 2048 encodes as 0 in the header length field
// Read latency is fixed; frame_copy's valid pipe is sized by it
// -----------------------------------------------
`ifndef SLINK_SETTINGS_SVH
`define SLINK_SETTINGS_SVH

// Source side addressing, 24-bit as seen by the copy engine
`define SLINK_SRC_ADDR_W 24

// Transmit buffer addressing, one frame of up to 2048 bytes
`define SLINK_BUF_ADDR_W 11

// First source byte of the frame window
`define SLINK_WIN_BASE 24'h300002

// Bytes per frame, 2 to 2048
`define SLINK_FRAME_LEN 32

// Low address bits actually decoded by the source memory
`define SLINK_RAM_ADDR_W 12

// Source read latency in cycles, not adjustable
`define SLINK_RD_LAT 2

// Link credits held after reset
`define SLINK_CREDITS 4

`endif
